/* src/cracker_pkg.sv */
package cracker_pkg;

	localparam int CAND_LEN = 3; // characters per candidate
	localparam int ALPHABET_SIZE = 36;
	localparam int NUM_TARGETS = 4;
	localparam int BLOCK_W = 512;
	localparam int DIGEST_W = 256;
	localparam int ROUNDS = 64;
	localparam int SHA_CREDITS = 1; // block slots inside the core

	typedef logic [5:0] sym_idx_t;
	typedef logic [7:0] char_t;
	typedef logic [CAND_LEN*8-1:0] cand_t; // first character in the top byte
	typedef logic [BLOCK_W-1:0] block_t;
	typedef logic [DIGEST_W-1:0] digest_t;
	typedef logic [31:0] word_t;
	typedef logic [$clog2(NUM_TARGETS)-1:0] tgt_idx_t;

	typedef struct packed {
		block_t block;
		cand_t cand;
	} block_msg_t;

	typedef struct packed {
		digest_t digest;
		cand_t cand;
	} digest_msg_t;

	localparam sym_idx_t SYM_MAX = sym_idx_t'(ALPHABET_SIZE - 1); // last symbol, wraps after it

	// letters first, then digits
	localparam char_t ALPHABET [ALPHABET_SIZE] = '{
		"a", "b", "c", "d", "e", "f", "g", "h", "i", "j", "k", "l", "m",
		"n", "o", "p", "q", "r", "s", "t", "u", "v", "w", "x", "y", "z",
		"0", "1", "2", "3", "4", "5", "6", "7", "8", "9"
	};

	localparam word_t SHA_K [ROUNDS] = '{
		32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
		32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
		32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
		32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
		32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
		32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
		32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
		32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
		32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
		32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
		32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
		32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
		32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
		32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
		32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
		32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
	};

	localparam word_t SHA_H0 [8] = '{
		32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
		32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19
	};

endpackage

/* src/credit_if.sv */
interface credit_if #(
	parameter type payload_t = logic
);

	logic valid; // one beat per spent credit
	logic last; // final candidate of the search space
	payload_t payload;
	logic credit; // receiver freed one slot

	modport sender (
		output valid,
		output last,
		output payload,
		input credit
	);

	modport receiver (
		input valid,
		input last,
		input payload,
		output credit
	);

endinterface

/* src/candidate_gen.sv */
module candidate_gen import cracker_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic start,
	credit_if.sender blk
);

	typedef logic [$clog2(SHA_CREDITS + 1)-1:0] cnt_t;

	sym_idx_t digit [CAND_LEN]; // digit 0 is the last character
	sym_idx_t digit_next [CAND_LEN];
	logic carry;
	logic at_end; // every digit at SYM_MAX
	cand_t cand_now;
	cnt_t credits;
	logic running;
	logic send;

	// odometer step and ascii mapping
	always_comb begin
		carry = 1'b1;
		at_end = 1'b1;
		for (int i = 0; i < CAND_LEN; i++) begin
			cand_now[i*8 +: 8] = ALPHABET[digit[i]];
			at_end = at_end & (digit[i] == SYM_MAX);
			digit_next[i] = digit[i];
			if (carry) begin
				if (digit[i] == SYM_MAX) begin
					digit_next[i] = '0; // wrap, carry on
				end else begin
					digit_next[i] = digit[i] + 1'b1;
					carry = 1'b0;
				end
			end
		end
	end

	// a credit arriving this cycle is usable at once
	assign send = (running || start) && (credits != '0 || blk.credit);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			running <= 1'b0;
			credits <= cnt_t'(SHA_CREDITS);
			blk.valid <= 1'b0;
			blk.last <= 1'b0;
			for (int i = 0; i < CAND_LEN; i++) begin
				digit[i] <= '0;
			end
		end else begin
			blk.valid <= send;
			credits <= credits + cnt_t'(blk.credit) - cnt_t'(send);
			if (start) begin
				running <= 1'b1;
			end
			if (send) begin
				blk.last <= at_end;
				for (int i = 0; i < CAND_LEN; i++) begin
					digit[i] <= digit_next[i];
				end
				if (at_end) begin
					running <= 1'b0; // search space exhausted
				end
			end
		end
	end

	// message bytes, the 0x80 pad byte, zeros, then the length in bits
	always_ff @(posedge clk) begin
		if (send) begin
			blk.payload.block <= {cand_now, 8'h80,
				{(BLOCK_W - CAND_LEN * 8 - 72){1'b0}}, 64'(CAND_LEN * 8)};
			blk.payload.cand <= cand_now;
		end
	end

endmodule

/* src/sha256_core.sv */
module sha256_core import cracker_pkg::*; (
	input logic clk,
	input logic rst_n,
	credit_if.receiver blk,
	credit_if.sender dig
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_ROUND,
		S_FINAL, // add to H0
		S_HOLD // digest ready, waiting for a credit
	} state_t;

	typedef logic [$clog2(ROUNDS)-1:0] rnd_t;

	state_t state;
	rnd_t round;
	word_t w [16]; // rolling schedule window, w[0] is W_t
	word_t a, b, c, d, e, f, g, h;
	cand_t cand_q;
	logic last_q;
	logic dig_cred; // single digest slot downstream
	logic send;

	word_t s0_a, s1_e, ch_efg, maj_abc;
	word_t t1, t2;
	word_t sg0, sg1, w_new;

	function automatic word_t rotr(input word_t x, input int n);
		return (x >> n) | (x << (32 - n));
	endfunction

	assign s1_e = rotr(e, 6) ^ rotr(e, 11) ^ rotr(e, 25);
	assign ch_efg = (e & f) ^ (~e & g);
	assign t1 = h + s1_e + ch_efg + SHA_K[round] + w[0];
	assign s0_a = rotr(a, 2) ^ rotr(a, 13) ^ rotr(a, 22);
	assign maj_abc = (a & b) ^ (a & c) ^ (b & c);
	assign t2 = s0_a + maj_abc;

	// W_{t+16} from the current window
	assign sg0 = rotr(w[1], 7) ^ rotr(w[1], 18) ^ (w[1] >> 3);
	assign sg1 = rotr(w[14], 17) ^ rotr(w[14], 19) ^ (w[14] >> 10);
	assign w_new = sg1 + w[9] + sg0 + w[0];

	assign send = (state == S_FINAL || state == S_HOLD) && (dig_cred || dig.credit);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= S_IDLE;
			round <= '0;
			dig.valid <= 1'b0;
			dig.last <= 1'b0;
			blk.credit <= 1'b0;
			dig_cred <= 1'b1;
		end else begin
			dig.valid <= 1'b0;
			blk.credit <= 1'b0;
			dig_cred <= (dig_cred | dig.credit) & ~send;
			case (state)
				S_IDLE: begin
					if (blk.valid) begin
						state <= S_ROUND;
						round <= '0;
					end
				end
				S_ROUND: begin
					round <= round + 1'b1;
					if (round == rnd_t'(ROUNDS - 1)) begin
						state <= S_FINAL;
					end
				end
				default: begin
					if (send) begin
						dig.valid <= 1'b1;
						dig.last <= last_q;
						blk.credit <= 1'b1; // block slot free again
						state <= S_IDLE;
					end else begin
						state <= S_HOLD;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == S_IDLE && blk.valid) begin
			for (int i = 0; i < 16; i++) begin
				w[i] <= blk.payload.block[BLOCK_W-1-32*i -: 32]; // big-endian words
			end
			a <= SHA_H0[0];
			b <= SHA_H0[1];
			c <= SHA_H0[2];
			d <= SHA_H0[3];
			e <= SHA_H0[4];
			f <= SHA_H0[5];
			g <= SHA_H0[6];
			h <= SHA_H0[7];
			cand_q <= blk.payload.cand;
			last_q <= blk.last;
		end else if (state == S_ROUND) begin
			for (int i = 0; i < 15; i++) begin
				w[i] <= w[i+1];
			end
			w[15] <= w_new;
			h <= g;
			g <= f;
			f <= e;
			e <= d + t1;
			d <= c;
			c <= b;
			b <= a;
			a <= t1 + t2;
		end else if (state == S_FINAL) begin
			dig.payload.digest <= {a + SHA_H0[0], b + SHA_H0[1], c + SHA_H0[2],
				d + SHA_H0[3], e + SHA_H0[4], f + SHA_H0[5], g + SHA_H0[6],
				h + SHA_H0[7]};
			dig.payload.cand <= cand_q;
		end
	end

endmodule

/* src/digest_match.sv */
module digest_match import cracker_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic target_we,
	input tgt_idx_t target_sel,
	input digest_t target_digest,
	credit_if.receiver dig,
	output logic [NUM_TARGETS-1:0] found,
	output logic match_valid,
	output tgt_idx_t match_target,
	output cand_t match_cand,
	output logic done
);

	digest_t targets [NUM_TARGETS];
	logic [NUM_TARGETS-1:0] hit;
	tgt_idx_t first_hit; // lowest matching index

	always_ff @(posedge clk) begin
		if (target_we) begin
			targets[target_sel] <= target_digest;
		end
	end

	always_comb begin
		first_hit = '0;
		for (int i = NUM_TARGETS - 1; i >= 0; i--) begin
			hit[i] = (dig.payload.digest == targets[i]);
			if (hit[i]) begin
				first_hit = tgt_idx_t'(i); // lower index overrides
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			found <= '0;
			match_valid <= 1'b0;
			done <= 1'b0;
			dig.credit <= 1'b0;
		end else begin
			match_valid <= dig.valid && (|hit);
			dig.credit <= dig.valid; // digest consumed in one cycle
			if (dig.valid) begin
				found <= found | hit; // sticky
				done <= done | dig.last;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (dig.valid && (|hit)) begin
			match_target <= first_hit;
			match_cand <= dig.payload.cand;
		end
	end

endmodule

/* src/hash_cracker_top.sv */
module hash_cracker_top import cracker_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic target_we,
	input tgt_idx_t target_sel,
	input digest_t target_digest,
	input logic start,
	output logic [NUM_TARGETS-1:0] found,
	output logic match_valid,
	output tgt_idx_t match_target,
	output cand_t match_cand,
	output logic done
);

	credit_if #(.payload_t(block_msg_t)) blk_ch (); // generator to core
	credit_if #(.payload_t(digest_msg_t)) dig_ch (); // core to match stage

	candidate_gen gen0 (
		.clk (clk),
		.rst_n (rst_n),
		.start (start),
		.blk (blk_ch.sender)
	);

	sha256_core core0 (
		.clk (clk),
		.rst_n (rst_n),
		.blk (blk_ch.receiver),
		.dig (dig_ch.sender)
	);

	digest_match match0 (
		.clk (clk),
		.rst_n (rst_n),
		.target_we (target_we),
		.target_sel (target_sel),
		.target_digest (target_digest),
		.dig (dig_ch.receiver),
		.found (found),
		.match_valid (match_valid),
		.match_target (match_target),
		.match_cand (match_cand),
		.done (done)
	);

endmodule

/* include/sha256_ref.svh */
`ifndef SHA256_REF_SVH
`define SHA256_REF_SVH

// straight from the standard, one block for a CAND_LEN byte message
function automatic word_t ref_rotr(input word_t x, input int n);
	return word_t'({x, x} >> n);
endfunction

function automatic digest_t sha256_ref(input cand_t msg);
	block_t blk;
	word_t w [64];
	word_t v [8];
	word_t s0, s1, ch, maj, t1, t2;
	digest_t res;

	blk = '0;
	blk[BLOCK_W-1 -: CAND_LEN*8] = msg;
	blk[BLOCK_W-1-CAND_LEN*8 -: 8] = 8'h80; // single 1 bit after the message
	blk[63:0] = 64'(CAND_LEN * 8);

	for (int i = 0; i < 16; i++) begin
		w[i] = blk[BLOCK_W-1-32*i -: 32];
	end
	for (int i = 16; i < 64; i++) begin
		s0 = ref_rotr(w[i-15], 7) ^ ref_rotr(w[i-15], 18) ^ (w[i-15] >> 3);
		s1 = ref_rotr(w[i-2], 17) ^ ref_rotr(w[i-2], 19) ^ (w[i-2] >> 10);
		w[i] = w[i-16] + s0 + w[i-7] + s1;
	end

	for (int i = 0; i < 8; i++) begin
		v[i] = SHA_H0[i];
	end

	// v holds a..h
	for (int i = 0; i < 64; i++) begin
		s1 = ref_rotr(v[4], 6) ^ ref_rotr(v[4], 11) ^ ref_rotr(v[4], 25);
		ch = (v[4] & v[5]) ^ (~v[4] & v[6]);
		t1 = v[7] + s1 + ch + SHA_K[i] + w[i];
		s0 = ref_rotr(v[0], 2) ^ ref_rotr(v[0], 13) ^ ref_rotr(v[0], 22);
		maj = (v[0] & v[1]) ^ (v[0] & v[2]) ^ (v[1] & v[2]);
		t2 = s0 + maj;
		v[7] = v[6];
		v[6] = v[5];
		v[5] = v[4];
		v[4] = v[3] + t1;
		v[3] = v[2];
		v[2] = v[1];
		v[1] = v[0];
		v[0] = t1 + t2;
	end

	for (int i = 0; i < 8; i++) begin
		res[DIGEST_W-1-32*i -: 32] = v[i] + SHA_H0[i];
	end
	return res;
endfunction

`endif

/* verif/tb_hash_cracker.sv */
module tb_hash_cracker import cracker_pkg::*; ();

	localparam int unsigned SPACE = ALPHABET_SIZE ** CAND_LEN; // odometer positions
	localparam int TIMEOUT = 5000000; // cycles per wait

	logic clk;
	logic rst_n;
	logic target_we;
	tgt_idx_t target_sel;
	digest_t target_digest;
	logic start;
	logic [NUM_TARGETS-1:0] found;
	logic match_valid;
	tgt_idx_t match_target;
	cand_t match_cand;
	logic done;

	int unsigned pick [3]; // odometer index behind targets 0..2
	cand_t pick_cand [3];
	digest_t stored [NUM_TARGETS]; // what was written into each target
	digest_t decoy;
	int match_cnt [3];
	longint last_idx;
	int done_rises;
	int errors;
	int timeouts;
	logic [NUM_TARGETS-1:0] prev_found;
	logic prev_done;

	`include "sha256_ref.svh"

	hash_cracker_top dut0 (
		.clk (clk),
		.rst_n (rst_n),
		.target_we (target_we),
		.target_sel (target_sel),
		.target_digest (target_digest),
		.start (start),
		.found (found),
		.match_valid (match_valid),
		.match_target (match_target),
		.match_cand (match_cand),
		.done (done)
	);

	always #2 clk = ~clk;

	// last character is the fastest digit
	function automatic cand_t index_to_cand(input int unsigned idx);
		cand_t c;
		int unsigned rest;
		rest = idx;
		for (int i = 0; i < CAND_LEN; i++) begin
			c[i*8 +: 8] = ALPHABET[rest % ALPHABET_SIZE];
			rest = rest / ALPHABET_SIZE;
		end
		return c;
	endfunction

	function automatic bit index_taken(input int n);
		for (int k = 0; k < n; k++) begin
			if (pick[k] == pick[n]) begin
				return 1'b1;
			end
		end
		return 1'b0;
	endfunction

	task automatic report_mismatch(input string msg);
		errors++;
		$display("Mismatch at %0t: %s", $time, msg);
	endtask

	task automatic check_idle();
		assert (found == '0 && !match_valid && !done)
			else report_mismatch($sformatf("outputs not idle before start, found=%b mv=%b done=%b",
				found, match_valid, done));
	endtask

	task automatic load_target(input int sel, input digest_t value);
		target_we = 1'b1;
		target_sel = tgt_idx_t'(sel);
		target_digest = value;
		stored[sel] = value;
		@(negedge clk);
		target_we = 1'b0;
		check_idle();
	endtask

	task automatic wait_for_done();
		int n;
		n = 0;
		while (!done && n < TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		if (!done) begin
			timeouts++;
			$display("Timeout at %0t: done did not rise within %0d cycles", $time, TIMEOUT);
		end
	endtask

	task automatic check_match();
		int j;
		j = -1;
		for (int k = 0; k < 3; k++) begin
			if (pick_cand[k] == match_cand) begin
				j = k;
			end
		end
		assert (j >= 0) else report_mismatch($sformatf("unexpected candidate %s", match_cand));
		assert (!prev_done) else report_mismatch("match reported after done");
		assert (sha256_ref(match_cand) == stored[match_target])
			else report_mismatch($sformatf("digest of %s differs from target %0d",
				match_cand, match_target));
		if (j >= 0) begin
			assert (match_target == tgt_idx_t'(j))
				else report_mismatch($sformatf("%s reported as target %0d, expected %0d",
					match_cand, match_target, j));
			assert (match_cnt[j] == 0)
				else report_mismatch($sformatf("target %0d matched more than once", j));
			assert (longint'(pick[j]) > last_idx)
				else report_mismatch($sformatf("%s out of odometer order", match_cand));
			match_cnt[j]++;
			last_idx = pick[j];
		end
	endtask

	// outputs are registered, so mid-cycle values are stable
	always @(negedge clk) begin
		if (rst_n) begin
			assert ((found & prev_found) == prev_found)
				else report_mismatch($sformatf("found fell from %b to %b", prev_found, found));
			assert (!(prev_done && !done)) else report_mismatch("done fell");
			if (done && !prev_done) begin
				done_rises++;
			end
			if (match_valid) begin
				check_match();
			end
			prev_found = found;
			prev_done = done;
		end
	end

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		start = 1'b0;
		target_we = 1'b0;
		target_sel = '0;
		target_digest = '0;
		errors = 0;
		timeouts = 0;
		done_rises = 0;
		last_idx = -1;
		prev_found = '0;
		prev_done = 1'b0;
		for (int j = 0; j < 3; j++) begin
			match_cnt[j] = 0;
		end
		void'($urandom(2));
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		check_idle();

		for (int j = 0; j < 3; j++) begin
			pick[j] = $urandom % SPACE;
			while (index_taken(j)) begin
				pick[j] = (pick[j] + 1) % SPACE; // keep the three strings distinct
			end
			pick_cand[j] = index_to_cand(pick[j]);
			load_target(j, sha256_ref(pick_cand[j]));
		end
		for (int i = 0; i < 8; i++) begin
			decoy[i*32 +: 32] = $urandom;
		end
		load_target(3, decoy); // never hit

		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		wait_for_done();

		if (timeouts == 0) begin
			assert (found[2:0] == 3'b111 && !found[3])
				else report_mismatch($sformatf("found=%b at done", found));
			repeat (16) @(negedge clk);
			assert (done_rises == 1)
				else report_mismatch($sformatf("done rose %0d times", done_rises));
			for (int j = 0; j < 3; j++) begin
				assert (match_cnt[j] == 1)
					else report_mismatch($sformatf("target %0d matched %0d times", j, match_cnt[j]));
			end
		end

		$display("error counts: %0d mismatches, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

/* project.f */
+incdir+include
src/cracker_pkg.sv
src/credit_if.sv
src/candidate_gen.sv
src/sha256_core.sv
src/digest_match.sv
src/hash_cracker_top.sv
verif/tb_hash_cracker.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_hash_cracker
FILELIST ?= project.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

# build, run, then look for the pass line in the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^sim passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
